/* rtl/axi_bus_pkg.sv */
package axi_bus_pkg;

    // byte address and data word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // master to slave, read side
    typedef struct packed {
        addr_t araddr;
        logic  arvalid;
        logic  rready;
    } rd_req_t;

    // master to slave, write side
    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
        data_t wdata;
        logic  wvalid;
        logic  bready;
    } wr_req_t;

    // slave to master, read side
    typedef struct packed {
        logic  arready;
        logic  rvalid;
        data_t rdata;
    } rd_rsp_t;

    // slave to master, write side
    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
    } wr_rsp_t;

    typedef enum logic [1:0] {arb_idle, arb_ifu_read, arb_lsu_read} arb_state_t;

    // order matches the crossbar's slave port index
    typedef enum logic [1:0] {sel_sram, sel_uart, sel_clint, sel_none} slave_sel_t;

    localparam addr_t SRAM_BASE  = 32'h8000_0000;
    localparam addr_t UART_BASE  = 32'ha000_03f8;
    localparam addr_t CLINT_BASE = 32'ha000_0048;

endpackage

/* rtl/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter
    import axi_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,

    // instruction fetch, read only
    input  rd_req_t ifu_rd,
    output rd_rsp_t ifu_rsp,

    // load/store unit
    input  rd_req_t lsu_rd,
    output rd_rsp_t lsu_rsp,
    input  wr_req_t lsu_wr,
    output wr_rsp_t lsu_wr_rsp,

    // toward the crossbar
    output rd_req_t bus_rd,
    input  rd_rsp_t bus_rd_rsp,
    output wr_req_t bus_wr,
    input  wr_rsp_t bus_wr_rsp
);

    arb_state_t state;
    arb_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_idle;
        end else begin
            state <= state_next;
        end
    end

    // ifu has priority when both ask in the same cycle
    always_comb begin
        state_next = state;
        case (state)
            arb_idle: begin
                if (ifu_rd.arvalid) begin
                    state_next = arb_ifu_read;
                end else if (lsu_rd.arvalid) begin
                    state_next = arb_lsu_read;
                end
            end
            arb_ifu_read: begin
                if (bus_rd_rsp.rvalid && ifu_rd.rready) begin
                    state_next = arb_idle;
                end
            end
            arb_lsu_read: begin
                if (bus_rd_rsp.rvalid && lsu_rd.rready) begin
                    state_next = arb_idle;
                end
            end
            default: state_next = arb_idle;
        endcase
    end

    // granted master sees the bus, the other one sees zeros
    always_comb begin
        bus_rd  = '0;
        ifu_rsp = '0;
        lsu_rsp = '0;
        case (state)
            arb_ifu_read: begin
                bus_rd  = ifu_rd;
                ifu_rsp = bus_rd_rsp;
            end
            arb_lsu_read: begin
                bus_rd  = lsu_rd;
                lsu_rsp = bus_rd_rsp;
            end
            default: begin
                bus_rd = '0;
            end
        endcase
    end

    // only the lsu writes
    assign bus_wr     = lsu_wr;
    assign lsu_wr_rsp = bus_wr_rsp;

endmodule

/* rtl/addr_xbar.sv */
`timescale 1ns/1ps

module addr_xbar
    import axi_bus_pkg::*;
#(
    parameter int unsigned SRAM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst,

    input  rd_req_t bus_rd,
    output rd_rsp_t bus_rd_rsp,
    input  wr_req_t bus_wr,
    output wr_rsp_t bus_wr_rsp,

    output rd_req_t sram_rd,
    input  rd_rsp_t sram_rd_rsp,
    output wr_req_t sram_wr,
    input  wr_rsp_t sram_wr_rsp,

    output rd_req_t uart_rd,
    input  rd_rsp_t uart_rd_rsp,
    output wr_req_t uart_wr,
    input  wr_rsp_t uart_wr_rsp,

    output rd_req_t clint_rd,
    input  rd_rsp_t clint_rd_rsp,
    output wr_req_t clint_wr,
    input  wr_rsp_t clint_wr_rsp
);

    localparam int unsigned N_SLAVES  = 3;
    localparam addr_t       SRAM_SPAN = addr_t'(SRAM_WORDS * 4);

    rd_req_t    s_rd     [N_SLAVES];
    rd_rsp_t    s_rd_rsp [N_SLAVES];
    wr_req_t    s_wr     [N_SLAVES];
    wr_rsp_t    s_wr_rsp [N_SLAVES];

    slave_sel_t rd_dec;
    slave_sel_t rd_sel;
    slave_sel_t wr_dec;
    slave_sel_t wr_sel;
    logic       rd_busy;
    logic       wr_busy;
    logic       none_rvalid;
    logic       none_bvalid;
    logic       ar_fire;
    logic       r_fire;
    logic       aw_fire;
    logic       b_fire;

    function automatic slave_sel_t decode(addr_t addr);
        slave_sel_t sel;
        sel = sel_none;
        // unsigned wrap keeps addresses below the base out of the window
        if (addr_t'(addr - SRAM_BASE) < SRAM_SPAN) begin
            sel = sel_sram;
        end else if (addr == UART_BASE) begin
            sel = sel_uart;
        end else if (addr == CLINT_BASE || addr == addr_t'(CLINT_BASE + 32'd4)) begin
            sel = sel_clint;
        end
        return sel;
    endfunction

    assign rd_dec = decode(bus_rd.araddr);
    assign wr_dec = decode(bus_wr.awaddr);

    // payload fans out, valid and ready only reach the chosen slave
    always_comb begin
        for (int i = 0; i < N_SLAVES; i++) begin
            s_rd[i].araddr  = bus_rd.araddr;
            s_rd[i].arvalid = bus_rd.arvalid && !rd_busy && (rd_dec == slave_sel_t'(i));
            s_rd[i].rready  = bus_rd.rready && rd_busy && (rd_sel == slave_sel_t'(i));
            s_wr[i].awaddr  = bus_wr.awaddr;
            s_wr[i].wdata   = bus_wr.wdata;
            s_wr[i].awvalid = bus_wr.awvalid && !wr_busy && (wr_dec == slave_sel_t'(i));
            s_wr[i].wvalid  = bus_wr.wvalid && !wr_busy && (wr_dec == slave_sel_t'(i));
            s_wr[i].bready  = bus_wr.bready && wr_busy && (wr_sel == slave_sel_t'(i));
        end
    end

    always_comb begin
        bus_rd_rsp = '0;
        if (!rd_busy) begin
            if (rd_dec == sel_none) begin
                bus_rd_rsp.arready = bus_rd.arvalid;
            end else begin
                bus_rd_rsp.arready = s_rd_rsp[rd_dec].arready;
            end
        end else if (rd_sel == sel_none) begin
            // unmapped read returns zero
            bus_rd_rsp.rvalid = none_rvalid;
        end else begin
            bus_rd_rsp.rvalid = s_rd_rsp[rd_sel].rvalid;
            bus_rd_rsp.rdata  = s_rd_rsp[rd_sel].rdata;
        end
    end

    always_comb begin
        bus_wr_rsp = '0;
        if (!wr_busy) begin
            if (wr_dec == sel_none) begin
                bus_wr_rsp.awready = bus_wr.awvalid && bus_wr.wvalid;
                bus_wr_rsp.wready  = bus_wr.awvalid && bus_wr.wvalid;
            end else begin
                bus_wr_rsp.awready = s_wr_rsp[wr_dec].awready;
                bus_wr_rsp.wready  = s_wr_rsp[wr_dec].wready;
            end
        end else if (wr_sel == sel_none) begin
            bus_wr_rsp.bvalid = none_bvalid;
        end else begin
            bus_wr_rsp.bvalid = s_wr_rsp[wr_sel].bvalid;
        end
    end

    assign ar_fire = bus_rd.arvalid && bus_rd_rsp.arready;
    assign r_fire  = bus_rd_rsp.rvalid && bus_rd.rready;
    // slaves take aw and w together, so aw marks the whole write
    assign aw_fire = bus_wr.awvalid && bus_wr_rsp.awready;
    assign b_fire  = bus_wr_rsp.bvalid && bus_wr.bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_busy     <= 1'b0;
            rd_sel      <= sel_none;
            none_rvalid <= 1'b0;
            wr_busy     <= 1'b0;
            wr_sel      <= sel_none;
            none_bvalid <= 1'b0;
        end else begin
            if (ar_fire) begin
                rd_busy     <= 1'b1;
                rd_sel      <= rd_dec;
                none_rvalid <= (rd_dec == sel_none);
            end else if (r_fire) begin
                rd_busy     <= 1'b0;
                none_rvalid <= 1'b0;
            end
            if (aw_fire) begin
                wr_busy     <= 1'b1;
                wr_sel      <= wr_dec;
                none_bvalid <= (wr_dec == sel_none);
            end else if (b_fire) begin
                wr_busy     <= 1'b0;
                none_bvalid <= 1'b0;
            end
        end
    end

    assign sram_rd  = s_rd[sel_sram];
    assign uart_rd  = s_rd[sel_uart];
    assign clint_rd = s_rd[sel_clint];
    assign sram_wr  = s_wr[sel_sram];
    assign uart_wr  = s_wr[sel_uart];
    assign clint_wr = s_wr[sel_clint];

    assign s_rd_rsp[sel_sram]  = sram_rd_rsp;
    assign s_rd_rsp[sel_uart]  = uart_rd_rsp;
    assign s_rd_rsp[sel_clint] = clint_rd_rsp;
    assign s_wr_rsp[sel_sram]  = sram_wr_rsp;
    assign s_wr_rsp[sel_uart]  = uart_wr_rsp;
    assign s_wr_rsp[sel_clint] = clint_wr_rsp;

endmodule

/* rtl/sram_slave.sv */
`timescale 1ns/1ps

module sram_slave
    import axi_bus_pkg::*;
#(
    parameter int unsigned SRAM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst,
    input  rd_req_t rd,
    output rd_rsp_t rd_rsp,
    input  wr_req_t wr,
    output wr_rsp_t wr_rsp
);

    localparam int unsigned IDX_W = $clog2(SRAM_WORDS);

    data_t            mem [SRAM_WORDS];
    data_t            rdata_q;
    logic             rd_pending;
    logic             wr_pending;
    logic             rd_accept;
    logic             wr_accept;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    // word index, upper address bits wrap around the depth
    assign rd_idx = rd.araddr[IDX_W+1:2];
    assign wr_idx = wr.awaddr[IDX_W+1:2];

    assign rd_accept = rd.arvalid && !rd_pending;
    assign wr_accept = wr.awvalid && wr.wvalid && !wr_pending;

    assign rd_rsp.arready = rd_accept;
    assign rd_rsp.rvalid  = rd_pending;
    assign rd_rsp.rdata   = rdata_q;

    assign wr_rsp.awready = wr_accept;
    assign wr_rsp.wready  = wr_accept;
    assign wr_rsp.bvalid  = wr_pending;

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata_q <= mem[rd_idx];
        end
        if (wr_accept) begin
            mem[wr_idx] <= wr.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending <= 1'b0;
            wr_pending <= 1'b0;
        end else begin
            if (rd_accept) begin
                rd_pending <= 1'b1;
            end else if (rd.rready) begin
                rd_pending <= 1'b0;
            end
            if (wr_accept) begin
                wr_pending <= 1'b1;
            end else if (wr.bready) begin
                wr_pending <= 1'b0;
            end
        end
    end

endmodule

/* rtl/uart_slave.sv */
`timescale 1ns/1ps

module uart_slave
    import axi_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  rd_req_t    rd,
    output rd_rsp_t    rd_rsp,
    input  wr_req_t    wr,
    output wr_rsp_t    wr_rsp,
    output logic       tx_valid,
    output logic [7:0] tx_data
);

    logic rd_pending;
    logic wr_pending;
    logic rd_accept;
    logic wr_accept;

    assign rd_accept = rd.arvalid && !rd_pending;
    assign wr_accept = wr.awvalid && wr.wvalid && !wr_pending;

    // single register, the address is not decoded further
    assign rd_rsp.arready = rd_accept;
    assign rd_rsp.rvalid  = rd_pending;
    assign rd_rsp.rdata   = {24'd0, tx_data};

    assign wr_rsp.awready = wr_accept;
    assign wr_rsp.wready  = wr_accept;
    assign wr_rsp.bvalid  = wr_pending;

    // held byte doubles as the read-back value
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            tx_data <= wr.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid   <= 1'b0;
            rd_pending <= 1'b0;
            wr_pending <= 1'b0;
        end else begin
            tx_valid <= wr_accept;
            if (rd_accept) begin
                rd_pending <= 1'b1;
            end else if (rd.rready) begin
                rd_pending <= 1'b0;
            end
            if (wr_accept) begin
                wr_pending <= 1'b1;
            end else if (wr.bready) begin
                wr_pending <= 1'b0;
            end
        end
    end

endmodule

/* rtl/clint_slave.sv */
`timescale 1ns/1ps

module clint_slave
    import axi_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  rd_req_t rd,
    output rd_rsp_t rd_rsp,
    input  wr_req_t wr,
    output wr_rsp_t wr_rsp
);

    logic [63:0] mtime;
    data_t       rdata_q;
    logic        rd_pending;
    logic        wr_pending;
    logic        rd_accept;
    logic        wr_accept;

    assign rd_accept = rd.arvalid && !rd_pending;
    assign wr_accept = wr.awvalid && wr.wvalid && !wr_pending;

    assign rd_rsp.arready = rd_accept;
    assign rd_rsp.rvalid  = rd_pending;
    assign rd_rsp.rdata   = rdata_q;

    // mtime is read only, writes just get a response
    assign wr_rsp.awready = wr_accept;
    assign wr_rsp.wready  = wr_accept;
    assign wr_rsp.bvalid  = wr_pending;

    // bit 2 picks the high word at base+4
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata_q <= rd.araddr[2] ? mtime[63:32] : mtime[31:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime      <= 64'd0;
            rd_pending <= 1'b0;
            wr_pending <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (rd_accept) begin
                rd_pending <= 1'b1;
            end else if (rd.rready) begin
                rd_pending <= 1'b0;
            end
            if (wr_accept) begin
                wr_pending <= 1'b1;
            end else if (wr.bready) begin
                wr_pending <= 1'b0;
            end
        end
    end

endmodule

/* rtl/soc_bus_top.sv */
`timescale 1ns/1ps

module soc_bus_top
    import axi_bus_pkg::*;
#(
    parameter int unsigned SRAM_WORDS = 256
) (
    input  logic       clk,
    input  logic       rst,
    input  rd_req_t    ifu_rd,
    output rd_rsp_t    ifu_rsp,
    input  rd_req_t    lsu_rd,
    output rd_rsp_t    lsu_rsp,
    input  wr_req_t    lsu_wr,
    output wr_rsp_t    lsu_wr_rsp,
    output logic       tx_valid,
    output logic [7:0] tx_data
);

    // arbiter to crossbar
    rd_req_t bus_rd;
    rd_rsp_t bus_rd_rsp;
    wr_req_t bus_wr;
    wr_rsp_t bus_wr_rsp;

    // crossbar to slaves
    rd_req_t sram_rd;
    rd_rsp_t sram_rd_rsp;
    wr_req_t sram_wr;
    wr_rsp_t sram_wr_rsp;
    rd_req_t uart_rd;
    rd_rsp_t uart_rd_rsp;
    wr_req_t uart_wr;
    wr_rsp_t uart_wr_rsp;
    rd_req_t clint_rd;
    rd_rsp_t clint_rd_rsp;
    wr_req_t clint_wr;
    wr_rsp_t clint_wr_rsp;

    bus_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .ifu_rd     (ifu_rd),
        .ifu_rsp    (ifu_rsp),
        .lsu_rd     (lsu_rd),
        .lsu_rsp    (lsu_rsp),
        .lsu_wr     (lsu_wr),
        .lsu_wr_rsp (lsu_wr_rsp),
        .bus_rd     (bus_rd),
        .bus_rd_rsp (bus_rd_rsp),
        .bus_wr     (bus_wr),
        .bus_wr_rsp (bus_wr_rsp)
    );

    addr_xbar #(
        .SRAM_WORDS (SRAM_WORDS)
    ) u_xbar (
        .clk          (clk),
        .rst          (rst),
        .bus_rd       (bus_rd),
        .bus_rd_rsp   (bus_rd_rsp),
        .bus_wr       (bus_wr),
        .bus_wr_rsp   (bus_wr_rsp),
        .sram_rd      (sram_rd),
        .sram_rd_rsp  (sram_rd_rsp),
        .sram_wr      (sram_wr),
        .sram_wr_rsp  (sram_wr_rsp),
        .uart_rd      (uart_rd),
        .uart_rd_rsp  (uart_rd_rsp),
        .uart_wr      (uart_wr),
        .uart_wr_rsp  (uart_wr_rsp),
        .clint_rd     (clint_rd),
        .clint_rd_rsp (clint_rd_rsp),
        .clint_wr     (clint_wr),
        .clint_wr_rsp (clint_wr_rsp)
    );

    sram_slave #(
        .SRAM_WORDS (SRAM_WORDS)
    ) u_sram (
        .clk    (clk),
        .rst    (rst),
        .rd     (sram_rd),
        .rd_rsp (sram_rd_rsp),
        .wr     (sram_wr),
        .wr_rsp (sram_wr_rsp)
    );

    uart_slave u_uart (
        .clk      (clk),
        .rst      (rst),
        .rd       (uart_rd),
        .rd_rsp   (uart_rd_rsp),
        .wr       (uart_wr),
        .wr_rsp   (uart_wr_rsp),
        .tx_valid (tx_valid),
        .tx_data  (tx_data)
    );

    clint_slave u_clint (
        .clk    (clk),
        .rst    (rst),
        .rd     (clint_rd),
        .rd_rsp (clint_rd_rsp),
        .wr     (clint_wr),
        .wr_rsp (clint_wr_rsp)
    );

endmodule

/* verif/soc_bus_tb.sv */
`timescale 1ns/1ps

module soc_bus_tb;
    import axi_bus_pkg::*;

    localparam int unsigned SRAM_WORDS = 256;
    localparam int N_TESTS = 6;
    localparam int MAX_TEST_CYCLES = 300;
    // six tests plus reset and margin give 2000 cycles of 10 ns
    localparam int WATCHDOG_CYCLES = N_TESTS * MAX_TEST_CYCLES + 200;

    logic       clk;
    logic       rst;
    rd_req_t    ifu_rd;
    rd_rsp_t    ifu_rsp;
    rd_req_t    lsu_rd;
    rd_rsp_t    lsu_rsp;
    wr_req_t    lsu_wr;
    wr_rsp_t    lsu_wr_rsp;
    logic       tx_valid;
    logic [7:0] tx_data;

    data_t      model [addr_t];
    int         error_count;
    int         tests_passed;
    int         tests_failed;
    int         tx_pulses;
    logic [7:0] tx_seen;

    soc_bus_top #(
        .SRAM_WORDS (SRAM_WORDS)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .ifu_rd     (ifu_rd),
        .ifu_rsp    (ifu_rsp),
        .lsu_rd     (lsu_rd),
        .lsu_rsp    (lsu_rsp),
        .lsu_wr     (lsu_wr),
        .lsu_wr_rsp (lsu_wr_rsp),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // uart pulses counted mid-cycle
    always @(negedge clk) begin
        if (tx_valid === 1'b1) begin
            tx_pulses <= tx_pulses + 1;
            tx_seen   <= tx_data;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run timed out after %0t, a bus handshake never completed", $time);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic log_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        if (error_count == errors_at_start) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", name, error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic do_read(input bit from_ifu, input addr_t addr, output data_t data,
                           output time t_rvalid);
        rd_rsp_t rsp;
        @(posedge clk);
        #1;
        if (from_ifu) begin
            ifu_rd = '{araddr: addr, arvalid: 1'b1, rready: 1'b1};
        end else begin
            lsu_rd = '{araddr: addr, arvalid: 1'b1, rready: 1'b1};
        end
        rsp = '0;
        while (!rsp.arready) begin
            @(negedge clk);
            rsp = from_ifu ? ifu_rsp : lsu_rsp;
        end
        @(posedge clk);
        #1;
        if (from_ifu) begin
            ifu_rd.arvalid = 1'b0;
        end else begin
            lsu_rd.arvalid = 1'b0;
        end
        rsp = '0;
        while (!rsp.rvalid) begin
            @(negedge clk);
            rsp = from_ifu ? ifu_rsp : lsu_rsp;
        end
        data     = rsp.rdata;
        t_rvalid = $time;
        @(posedge clk);
        #1;
        if (from_ifu) begin
            ifu_rd.rready = 1'b0;
        end else begin
            lsu_rd.rready = 1'b0;
        end
    endtask

    task automatic do_write(input addr_t addr, input data_t data);
        @(posedge clk);
        #1;
        lsu_wr = '{awaddr: addr, awvalid: 1'b1, wdata: data, wvalid: 1'b1, bready: 1'b1};
        @(negedge clk);
        while (!lsu_wr_rsp.awready) begin
            @(negedge clk);
        end
        // aw and w are taken in the same cycle
        if (!lsu_wr_rsp.wready) begin
            log_error($sformatf("wready low while awready high for write to %h", addr));
        end
        @(posedge clk);
        #1;
        lsu_wr.awvalid = 1'b0;
        lsu_wr.wvalid  = 1'b0;
        @(negedge clk);
        while (!lsu_wr_rsp.bvalid) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        lsu_wr.bready = 1'b0;
    endtask

    task automatic test_reset_state();
        int start;
        start = error_count;
        @(negedge clk);
        if (ifu_rsp.rvalid || ifu_rsp.arready || lsu_rsp.rvalid || lsu_rsp.arready) begin
            log_error("read handshake outputs not low after reset");
        end
        if (lsu_wr_rsp.bvalid || tx_valid) begin
            log_error("bvalid or tx_valid not low after reset");
        end
        finish_test("reset state", start);
    endtask

    task automatic test_sram_write_read();
        int    start;
        addr_t a;
        data_t d;
        data_t got;
        time   t;
        start = error_count;
        for (int i = 0; i < 8; i++) begin
            a = SRAM_BASE + addr_t'(i * 17 * 4);
            d = $urandom();
            do_write(a, d);
            model[a] = d;
        end
        // both masters read every word back
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < 8; i++) begin
                a = SRAM_BASE + addr_t'(i * 17 * 4);
                do_read(m == 0, a, got, t);
                if (got !== model[a]) begin
                    log_error($sformatf("sram read %h got %h expected %h", a, got, model[a]));
                end
            end
        end
        finish_test("sram write and read back", start);
    endtask

    task automatic test_read_priority();
        int    start;
        addr_t a_ifu;
        addr_t a_lsu;
        data_t d_ifu;
        data_t d_lsu;
        time   t_ifu;
        time   t_lsu;
        start = error_count;
        a_ifu = SRAM_BASE + addr_t'(17 * 4);
        a_lsu = SRAM_BASE + addr_t'(34 * 4);
        fork
            do_read(1'b1, a_ifu, d_ifu, t_ifu);
            do_read(1'b0, a_lsu, d_lsu, t_lsu);
        join
        if (t_ifu >= t_lsu) begin
            log_error("lsu got rvalid before ifu in a same-cycle request");
        end
        if (d_ifu !== model[a_ifu] || d_lsu !== model[a_lsu]) begin
            log_error($sformatf("contended reads got %h and %h", d_ifu, d_lsu));
        end
        finish_test("arbiter priority", start);
    endtask

    task automatic test_uart();
        int    start;
        int    pulses_before;
        data_t d;
        data_t got;
        time   t;
        start         = error_count;
        pulses_before = tx_pulses;
        d             = $urandom();
        do_write(UART_BASE, d);
        repeat (4) @(posedge clk);
        if (tx_pulses - pulses_before != 1) begin
            log_error($sformatf("%0d tx_valid pulses for one write", tx_pulses - pulses_before));
        end
        if (tx_seen !== d[7:0]) begin
            log_error($sformatf("tx_data %h expected %h", tx_seen, d[7:0]));
        end
        do_read(1'b0, UART_BASE, got, t);
        if (got !== {24'd0, d[7:0]}) begin
            log_error($sformatf("uart read back %h expected %h", got, {24'd0, d[7:0]}));
        end
        finish_test("uart transmit register", start);
    endtask

    task automatic test_clint();
        int    start;
        data_t t1;
        data_t t2;
        data_t hi;
        time   t;
        start = error_count;
        do_read(1'b0, CLINT_BASE, t1, t);
        repeat (20) @(posedge clk);
        do_read(1'b0, CLINT_BASE, t2, t);
        if (t2 - t1 < 32'd20) begin
            log_error($sformatf("mtime went from %0d to %0d", t1, t2));
        end
        do_read(1'b0, CLINT_BASE + 32'd4, hi, t);
        if (hi !== 32'd0) begin
            log_error($sformatf("mtime high word %h expected 0", hi));
        end
        finish_test("clint mtime", start);
    endtask

    task automatic test_unmapped();
        int    start;
        data_t got;
        time   t;
        start = error_count;
        do_read(1'b0, 32'h1000_0000, got, t);
        if (got !== 32'd0) begin
            log_error($sformatf("unmapped read got %h", got));
        end
        // just past the sram window and aliasing word 0 if decoded
        do_write(SRAM_BASE + addr_t'(SRAM_WORDS * 4), $urandom());
        do_read(1'b0, SRAM_BASE, got, t);
        if (got !== model[SRAM_BASE]) begin
            log_error($sformatf("sram word 0 changed to %h", got));
        end
        finish_test("unmapped access", start);
    endtask

    initial begin
        int seed_state;
        rst          = 1'b1;
        ifu_rd       = '0;
        lsu_rd       = '0;
        lsu_wr       = '0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        tx_pulses    = 0;
        tx_seen      = '0;
        seed_state   = $urandom(63);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_state();
        test_sram_write_read();
        test_read_priority();
        test_uart();
        test_clint();
        test_unmapped();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* soc_bus.f */
rtl/axi_bus_pkg.sv
rtl/bus_arbiter.sv
rtl/addr_xbar.sv
rtl/sram_slave.sv
rtl/uart_slave.sv
rtl/clint_slave.sv
rtl/soc_bus_top.sv
verif/soc_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module soc_bus_tb -f soc_bus.f -o soc_bus_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/soc_bus_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^STATUS: PASS$"; then
    exit 0
fi
exit 1
